// ==== logic/vec_settings.svh ====
//////////////////////////////////////////////////////////////////////
// Vector unit settings
// Element width, maximum vector length and register count
//////////////////////////////////////////////////////////////////////
`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

// SEW is fixed for the whole unit
`define VEC_ELEM_WIDTH 32

// Elements per vector register
`define VEC_VLMAX 8

// Architectural vector registers
`define VEC_NUM_REGS 8

`endif

// ==== logic/vec_types_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Vector unit data types
// Element, register number, element index and vector length
//////////////////////////////////////////////////////////////////////
`default_nettype none

`include "vec_settings.svh"

package vec_types_pkg;

    // One element of a vector register
    typedef logic [`VEC_ELEM_WIDTH-1:0] elem_t;

    // Vector register number
    typedef logic [$clog2(`VEC_NUM_REGS)-1:0] vreg_addr_t;

    // Element position inside a register
    typedef logic [$clog2(`VEC_VLMAX)-1:0] elem_idx_t;

    // Vector length, 0 up to VLMAX inclusive
    typedef logic [$clog2(`VEC_VLMAX+1)-1:0] vl_t;

endpackage

`default_nettype wire

// ==== logic/vec_ctrl_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Vector unit control types
// Operation codes and sequencer states
//////////////////////////////////////////////////////////////////////
`default_nettype none

package vec_ctrl_pkg;

    // Per-element ALU operations
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_MINU = 4'd6,
        OP_MAXU = 4'd7,
        OP_MV_X = 4'd8,
        OP_VID  = 4'd9
    } vec_op_e;

    // Instruction sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE = 2'd0,
        SEQ_RUN  = 2'd1,
        SEQ_DONE = 2'd2
    } seq_state_e;

endpackage

`default_nettype wire

// ==== logic/vec_decode.sv ====
//////////////////////////////////////////////////////////////////////
// Vector decode
// Holds the vl CSR and latches instruction fields at issue
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "vec_settings.svh"

module vec_decode (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       busy,
    //vl CSR write
    input  logic                       vl_wr,
    input  vec_types_pkg::vl_t         vl_in,
    //Instruction issue
    input  logic                       issue,
    input  vec_ctrl_pkg::vec_op_e      op,
    input  vec_types_pkg::vreg_addr_t  vd,
    input  vec_types_pkg::vreg_addr_t  vs1,
    input  vec_types_pkg::vreg_addr_t  vs2,
    input  vec_types_pkg::elem_t       scalar,
    input  logic                       use_scalar,
    //Current CSR and latched fields
    output vec_types_pkg::vl_t         vl,
    output vec_ctrl_pkg::vec_op_e      op_q,
    output vec_types_pkg::vreg_addr_t  vd_q,
    output vec_types_pkg::vreg_addr_t  vs1_q,
    output vec_types_pkg::vreg_addr_t  vs2_q,
    output vec_types_pkg::elem_t       scalar_q,
    output logic                       use_scalar_q
);

    vec_types_pkg::vl_t vl_clamped;

    // Requests above VLMAX saturate
    assign vl_clamped = (vl_in > vec_types_pkg::vl_t'(`VEC_VLMAX)) ?
                        vec_types_pkg::vl_t'(`VEC_VLMAX) : vl_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            vl <= vec_types_pkg::vl_t'(`VEC_VLMAX);
        end else if (vl_wr && !busy) begin
            vl <= vl_clamped;
        end
    end

    // Fields stay put until the next accepted issue
    always_ff @(posedge clk) begin
        if (issue && !busy) begin
            op_q         <= op;
            vd_q         <= vd;
            vs1_q        <= vs1;
            vs2_q        <= vs2;
            scalar_q     <= scalar;
            use_scalar_q <= use_scalar;
        end
    end

    // vl must not move under a running instruction
    vl_wr_idle: assert property (@(posedge clk) disable iff (reset) vl_wr |-> !busy)
        else $error("vl written while an instruction is running");

endmodule

`default_nettype wire

// ==== logic/vec_sequencer.sv ====
//////////////////////////////////////////////////////////////////////
// Vector sequencer
// Runs one instruction across its elements, one per clock
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vec_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic issue,
    //From the element counter
    input  logic last,
    input  logic empty,
    //Status
    output logic busy,
    output logic done,
    //Counter and write control
    output logic count_clear,
    output logic count_step,
    output logic elem_wr
);

    vec_ctrl_pkg::seq_state_e state;
    vec_ctrl_pkg::seq_state_e state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= vec_ctrl_pkg::SEQ_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            vec_ctrl_pkg::SEQ_IDLE: begin
                if (issue) begin
                    state_next = vec_ctrl_pkg::SEQ_RUN;
                end
            end
            vec_ctrl_pkg::SEQ_RUN: begin
                // An empty vector still spends one cycle here
                if (last || empty) begin
                    state_next = vec_ctrl_pkg::SEQ_DONE;
                end
            end
            vec_ctrl_pkg::SEQ_DONE: begin
                state_next = vec_ctrl_pkg::SEQ_IDLE;
            end
            default: begin
                state_next = vec_ctrl_pkg::SEQ_IDLE;
            end
        endcase
    end

    assign busy        = (state != vec_ctrl_pkg::SEQ_IDLE);
    assign done        = (state == vec_ctrl_pkg::SEQ_DONE);
    assign count_clear = issue && (state == vec_ctrl_pkg::SEQ_IDLE);
    assign count_step  = (state == vec_ctrl_pkg::SEQ_RUN) && !empty;
    assign elem_wr     = count_step;

    // Only one instruction in flight
    issue_idle: assert property (@(posedge clk) disable iff (reset) issue |-> !busy)
        else $error("issue while busy");

endmodule

`default_nettype wire

// ==== logic/vec_element_counter.sv ====
//////////////////////////////////////////////////////////////////////
// Element counter
// Walks the element index and flags the last and empty cases
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vec_element_counter (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       clear,
    input  logic                       step,
    input  vec_types_pkg::vl_t         vl,
    output vec_types_pkg::elem_idx_t   idx,
    output logic                       last,
    output logic                       empty
);

    always_ff @(posedge clk) begin
        if (reset) begin
            idx <= '0;
        end else if (clear) begin
            idx <= '0;
        end else if (step && !last) begin
            idx <= idx + 1'b1;
        end
    end

    // vl of zero wraps vl-1 to all ones, so last stays low
    assign last  = ({1'b0, idx} == (vl - 1'b1));
    assign empty = (vl == '0);

    // Stepping beyond vl would mean the index runs off the register
    idx_in_range: assert property (@(posedge clk) disable iff (reset)
        step |-> ({1'b0, idx} < vl))
        else $error("element index stepped past vl");

endmodule

`default_nettype wire

// ==== logic/vec_regfile.sv ====
//////////////////////////////////////////////////////////////////////
// Vector register file
// Element addressed, two operand reads, one write, one debug read
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "vec_settings.svh"

module vec_regfile (
    input  logic                       clk,
    input  logic                       reset,
    //Operand reads and write share the element index
    input  vec_types_pkg::vreg_addr_t  rd_a_reg,
    input  vec_types_pkg::vreg_addr_t  rd_b_reg,
    input  vec_types_pkg::elem_idx_t   idx,
    input  logic                       wr_en,
    input  vec_types_pkg::vreg_addr_t  wr_reg,
    input  vec_types_pkg::elem_t       wr_data,
    output vec_types_pkg::elem_t       rd_a_data,
    output vec_types_pkg::elem_t       rd_b_data,
    //Debug read
    input  vec_types_pkg::vreg_addr_t  dbg_reg,
    input  vec_types_pkg::elem_idx_t   dbg_idx,
    output vec_types_pkg::elem_t       dbg_data
);

    vec_types_pkg::elem_t mem [`VEC_NUM_REGS][`VEC_VLMAX];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < `VEC_NUM_REGS; r++) begin
                for (int e = 0; e < `VEC_VLMAX; e++) begin
                    mem[r][e] <= '0;
                end
            end
        end else if (wr_en) begin
            mem[wr_reg][idx] <= wr_data;
        end
    end

    // Reads see the old value, so vd may equal a source
    assign rd_a_data = mem[rd_a_reg][idx];
    assign rd_b_data = mem[rd_b_reg][idx];

    assign dbg_data  = mem[dbg_reg][dbg_idx];

endmodule

`default_nettype wire

// ==== logic/vec_alu.sv ====
//////////////////////////////////////////////////////////////////////
// Vector ALU
// Combinational integer operation on one element
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vec_alu (
    input  vec_ctrl_pkg::vec_op_e      op,
    input  logic                       use_scalar,
    input  vec_types_pkg::elem_t       scalar,
    input  vec_types_pkg::elem_t       src_a,
    input  vec_types_pkg::elem_t       src_b,
    input  vec_types_pkg::elem_idx_t   idx,
    output vec_types_pkg::elem_t       result
);

    vec_types_pkg::elem_t op_a;

    // .vx forms take the scalar in place of vs1
    assign op_a = use_scalar ? scalar : src_a;

    always_comb begin
        case (op)
            vec_ctrl_pkg::OP_ADD: begin
                result = op_a + src_b;
            end
            vec_ctrl_pkg::OP_SUB: begin
                result = op_a - src_b;
            end
            vec_ctrl_pkg::OP_AND: begin
                result = op_a & src_b;
            end
            vec_ctrl_pkg::OP_OR: begin
                result = op_a | src_b;
            end
            vec_ctrl_pkg::OP_XOR: begin
                result = op_a ^ src_b;
            end
            vec_ctrl_pkg::OP_SLL: begin
                // Shift amount is the low 5 bits
                result = op_a << src_b[4:0];
            end
            vec_ctrl_pkg::OP_MINU: begin
                result = (op_a < src_b) ? op_a : src_b;
            end
            vec_ctrl_pkg::OP_MAXU: begin
                result = (op_a > src_b) ? op_a : src_b;
            end
            vec_ctrl_pkg::OP_MV_X: begin
                result = op_a;
            end
            vec_ctrl_pkg::OP_VID: begin
                result = vec_types_pkg::elem_t'(idx);
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/vec_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Vector execution unit top
// One instruction in flight, one element per clock
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module vec_unit (
    input  logic                       clk,
    input  logic                       reset,
    //vl CSR
    input  logic                       vl_wr,
    input  vec_types_pkg::vl_t         vl_in,
    output vec_types_pkg::vl_t         vl_out,
    //Instruction issue
    input  logic                       issue,
    input  vec_ctrl_pkg::vec_op_e      op,
    input  vec_types_pkg::vreg_addr_t  vd,
    input  vec_types_pkg::vreg_addr_t  vs1,
    input  vec_types_pkg::vreg_addr_t  vs2,
    input  vec_types_pkg::elem_t       scalar,
    input  logic                       use_scalar,
    //Status
    output logic                       busy,
    output logic                       done,
    //Debug read
    input  vec_types_pkg::vreg_addr_t  dbg_reg,
    input  vec_types_pkg::elem_idx_t   dbg_idx,
    output vec_types_pkg::elem_t       dbg_data
);

    vec_ctrl_pkg::vec_op_e      op_q;
    vec_types_pkg::vreg_addr_t  vd_q;
    vec_types_pkg::vreg_addr_t  vs1_q;
    vec_types_pkg::vreg_addr_t  vs2_q;
    vec_types_pkg::elem_t       scalar_q;
    logic                       use_scalar_q;
    vec_types_pkg::elem_idx_t   idx;
    logic                       last;
    logic                       empty;
    logic                       count_clear;
    logic                       count_step;
    logic                       elem_wr;
    vec_types_pkg::elem_t       rd_a_data;
    vec_types_pkg::elem_t       rd_b_data;
    vec_types_pkg::elem_t       alu_result;

    vec_decode decode_inst (
        .clk(clk), .reset(reset), .busy(busy),
        .vl_wr(vl_wr), .vl_in(vl_in),
        .issue(issue), .op(op), .vd(vd), .vs1(vs1), .vs2(vs2),
        .scalar(scalar), .use_scalar(use_scalar),
        .vl(vl_out), .op_q(op_q), .vd_q(vd_q), .vs1_q(vs1_q), .vs2_q(vs2_q),
        .scalar_q(scalar_q), .use_scalar_q(use_scalar_q)
    );

    vec_sequencer sequencer_inst (
        .clk(clk), .reset(reset), .issue(issue),
        .last(last), .empty(empty),
        .busy(busy), .done(done),
        .count_clear(count_clear), .count_step(count_step), .elem_wr(elem_wr)
    );

    vec_element_counter counter_inst (
        .clk(clk), .reset(reset),
        .clear(count_clear), .step(count_step), .vl(vl_out),
        .idx(idx), .last(last), .empty(empty)
    );

    vec_regfile regfile_inst (
        .clk(clk), .reset(reset),
        .rd_a_reg(vs1_q), .rd_b_reg(vs2_q), .idx(idx),
        .wr_en(elem_wr), .wr_reg(vd_q), .wr_data(alu_result),
        .rd_a_data(rd_a_data), .rd_b_data(rd_b_data),
        .dbg_reg(dbg_reg), .dbg_idx(dbg_idx), .dbg_data(dbg_data)
    );

    vec_alu alu_inst (
        .op(op_q), .use_scalar(use_scalar_q), .scalar(scalar_q),
        .src_a(rd_a_data), .src_b(rd_b_data), .idx(idx),
        .result(alu_result)
    );

endmodule

`default_nettype wire

// ==== tests/vec_unit_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Vector unit testbench
// Shadow register model, random operands and debug port readback
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "vec_settings.svh"

module vec_unit_tb;

    // About 80 issues or register dumps, each under 2*(VLMAX+4) cycles
    localparam int TIMEOUT_CYCLES = 80 * 2 * (`VEC_VLMAX + 4);

    logic                       clk;
    logic                       reset;
    logic                       vl_wr;
    vec_types_pkg::vl_t         vl_in;
    vec_types_pkg::vl_t         vl_out;
    logic                       issue;
    vec_ctrl_pkg::vec_op_e      op;
    vec_types_pkg::vreg_addr_t  vd;
    vec_types_pkg::vreg_addr_t  vs1;
    vec_types_pkg::vreg_addr_t  vs2;
    vec_types_pkg::elem_t       scalar;
    logic                       use_scalar;
    logic                       busy;
    logic                       done;
    vec_types_pkg::vreg_addr_t  dbg_reg;
    vec_types_pkg::elem_idx_t   dbg_idx;
    vec_types_pkg::elem_t       dbg_data;

    // Expected register contents and vl
    vec_types_pkg::elem_t       shadow [`VEC_NUM_REGS][`VEC_VLMAX];
    int                         model_vl;
    logic [31:0]                lcg_state;
    logic                       cmp_valid;
    vec_types_pkg::elem_t       cmp_expect;
    int                         cycle_count;
    int                         check_count;
    int                         error_count;
    int                         test_errors;

    vec_unit vec_unit_inst (
        .clk(clk), .reset(reset),
        .vl_wr(vl_wr), .vl_in(vl_in), .vl_out(vl_out),
        .issue(issue), .op(op), .vd(vd), .vs1(vs1), .vs2(vs2),
        .scalar(scalar), .use_scalar(use_scalar),
        .busy(busy), .done(done),
        .dbg_reg(dbg_reg), .dbg_idx(dbg_idx), .dbg_data(dbg_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the vector unit did not finish within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Debug port readback, one element per cycle
    always @(negedge clk) begin
        if (cmp_valid) begin
            check_value(dbg_data, cmp_expect, $sformatf("v%0d[%0d]", dbg_reg, dbg_idx));
        end
    end

    function automatic vec_types_pkg::elem_t elem_ref(input vec_ctrl_pkg::vec_op_e f,
        input vec_types_pkg::elem_t a, input vec_types_pkg::elem_t b, input int i);
        vec_types_pkg::elem_t r;
        case (f)
            vec_ctrl_pkg::OP_ADD:  r = a + b;
            vec_ctrl_pkg::OP_SUB:  r = a - b;
            vec_ctrl_pkg::OP_AND:  r = a & b;
            vec_ctrl_pkg::OP_OR:   r = a | b;
            vec_ctrl_pkg::OP_XOR:  r = a ^ b;
            vec_ctrl_pkg::OP_SLL:  r = a << b[4:0];
            vec_ctrl_pkg::OP_MINU: r = (b < a) ? b : a;
            vec_ctrl_pkg::OP_MAXU: r = (b > a) ? b : a;
            vec_ctrl_pkg::OP_MV_X: r = a;
            vec_ctrl_pkg::OP_VID:  r = vec_types_pkg::elem_t'(i);
            default:               r = '0;
        endcase
        return r;
    endfunction

    // Halves swapped so the weak low bits do not land in the shift amount
    function automatic vec_types_pkg::elem_t rand_elem();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    task automatic set_vl(input int n);
        @(posedge clk);
        vl_wr <= 1'b1;
        vl_in <= vec_types_pkg::vl_t'(n);
        @(posedge clk);
        vl_wr <= 1'b0;
        model_vl = (n > `VEC_VLMAX) ? `VEC_VLMAX : n;
    endtask

    task automatic run_instr(input vec_ctrl_pkg::vec_op_e f, input int d, input int s1,
                             input int s2, input vec_types_pkg::elem_t x, input logic vx);
        int busy_cycles;
        int done_pulses;
        vec_types_pkg::elem_t a;
        @(posedge clk);
        issue      <= 1'b1;
        op         <= f;
        vd         <= vec_types_pkg::vreg_addr_t'(d);
        vs1        <= vec_types_pkg::vreg_addr_t'(s1);
        vs2        <= vec_types_pkg::vreg_addr_t'(s2);
        scalar     <= x;
        use_scalar <= vx;
        @(posedge clk);
        issue <= 1'b0;
        busy_cycles = 0;
        done_pulses = 0;
        do begin
            @(negedge clk);
            if (busy) busy_cycles++;
            if (done) done_pulses++;
        end while (busy);
        check_value(busy_cycles, (model_vl == 0) ? 2 : model_vl + 1, "busy cycles");
        check_value(done_pulses, 1, "done pulses");
        // Same index read then written, so vd may overlap a source
        for (int i = 0; i < model_vl; i++) begin
            a = vx ? x : shadow[s1][i];
            shadow[d][i] = elem_ref(f, a, shadow[s2][i], i);
        end
    endtask

    task automatic compare_reg(input int r);
        for (int i = 0; i < `VEC_VLMAX; i++) begin
            @(posedge clk);
            dbg_reg    <= vec_types_pkg::vreg_addr_t'(r);
            dbg_idx    <= vec_types_pkg::elem_idx_t'(i);
            cmp_expect <= shadow[r][i];
            cmp_valid  <= 1'b1;
        end
        @(posedge clk);
        cmp_valid <= 1'b0;
    endtask

    // Shrinking vl gives every element its own random value
    task automatic load_random(input int r);
        for (int n = `VEC_VLMAX; n >= 1; n--) begin
            set_vl(n);
            run_instr(vec_ctrl_pkg::OP_MV_X, r, 0, 0, rand_elem(), 1'b1);
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %s", name, (error_count == test_errors) ? "pass" : "fail");
        test_errors = error_count;
    endtask

    initial begin
        vec_ctrl_pkg::vec_op_e f;
        reset      = 1'b1;
        vl_wr      = 1'b0;
        vl_in      = '0;
        issue      = 1'b0;
        op         = vec_ctrl_pkg::OP_ADD;
        vd         = '0;
        vs1        = '0;
        vs2        = '0;
        scalar     = '0;
        use_scalar = 1'b0;
        dbg_reg    = '0;
        dbg_idx    = '0;
        cmp_valid  = 1'b0;
        cmp_expect = '0;
        model_vl   = `VEC_VLMAX;
        lcg_state  = 32'd31;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        test_errors = 0;
        for (int r = 0; r < `VEC_NUM_REGS; r++) begin
            for (int e = 0; e < `VEC_VLMAX; e++) begin
                shadow[r][e] = '0;
            end
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_value(vl_out, `VEC_VLMAX, "vl after reset");
        check_value(busy, 0, "busy after reset");
        check_value(done, 0, "done after reset");
        for (int r = 0; r < `VEC_NUM_REGS; r++) begin
            compare_reg(r);
        end
        end_test("reset state");

        run_instr(vec_ctrl_pkg::OP_MV_X, 1, 0, 0, rand_elem(), 1'b1);
        run_instr(vec_ctrl_pkg::OP_VID, 2, 0, 0, '0, 1'b0);
        compare_reg(1);
        compare_reg(2);
        end_test("broadcast and index");

        load_random(3);
        load_random(4);
        set_vl(8);
        compare_reg(3);
        compare_reg(4);
        for (int k = 0; k < 8; k++) begin
            f = vec_ctrl_pkg::vec_op_e'(k[3:0]);
            run_instr(f, 5, 3, 4, '0, 1'b0);
            compare_reg(5);
            run_instr(f, 6, 0, 4, rand_elem(), 1'b1);
            compare_reg(6);
        end
        end_test("alu operations");

        run_instr(vec_ctrl_pkg::OP_MV_X, 7, 0, 0, rand_elem(), 1'b1);
        set_vl(3);
        @(negedge clk);
        check_value(vl_out, 3, "vl written");
        run_instr(vec_ctrl_pkg::OP_ADD, 7, 3, 4, '0, 1'b0);
        compare_reg(7);
        set_vl(12);
        @(negedge clk);
        check_value(vl_out, `VEC_VLMAX, "vl clamped");
        end_test("tail undisturbed");

        set_vl(5);
        run_instr(vec_ctrl_pkg::OP_XOR, 5, 3, 4, '0, 1'b0);
        compare_reg(5);
        set_vl(0);
        run_instr(vec_ctrl_pkg::OP_MV_X, 1, 0, 0, rand_elem(), 1'b1);
        compare_reg(1);
        set_vl(8);
        end_test("busy and done timing");

        run_instr(vec_ctrl_pkg::OP_ADD, 3, 3, 4, '0, 1'b0);
        compare_reg(3);
        run_instr(vec_ctrl_pkg::OP_SUB, 4, 3, 4, '0, 1'b0);
        compare_reg(4);
        end_test("overlapping registers");

        $display("Checks run: %0d, failed: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+logic
logic/vec_types_pkg.sv
logic/vec_ctrl_pkg.sv
logic/vec_decode.sv
logic/vec_sequencer.sv
logic/vec_element_counter.sv
logic/vec_regfile.sv
logic/vec_alu.sv
logic/vec_unit.sv
tests/vec_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the vector unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module vec_unit_tb \
    -o vec_unit_sim

./obj_dir/vec_unit_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
